// ==== logic/ringBusPkg.sv ====
package ringBusPkg;

	// ring message field widths
	localparam int ringAddrWidth = 32;
	localparam int ringSeqWidth = 16;
	localparam int ringOpmWidth = 16;
	localparam int ringOpcodeWidth = 8;

	// one ring data tile
	localparam int tileWidth = 128;

	// opm low byte
	// requests sit in the upper half, responses carry 2'b01 in bits 7:6
	typedef enum logic [ringOpcodeWidth-1:0] {
		IDLE = 8'h00,
		LDX = 8'h93,
		STX = 8'h97,
		PFX = 8'h9B,
		SPX = 8'h9F,
		OKLD = 8'h60,
		OKST = 8'h61
	} ringOpcode;

endpackage

// ==== logic/l2CachePkg.sv ====
package l2CachePkg;

	// line geometry
	localparam int lineTiles = 4;
	localparam int tileSelBits = $clog2(lineTiles);
	localparam int lineWidth = lineTiles * ringBusPkg::tileWidth;
	localparam int lineOffsetBits = 6;
	localparam int lineAddrWidth = ringBusPkg::ringAddrWidth - lineOffsetBits;

	// direct mapped, so the tag keeps the whole line address
	localparam int tagWidth = lineAddrWidth;
	localparam int indexBits = 8;
	localparam int lineCount = 1 << indexBits;

	// DDR port
	localparam int ddrAddrWidth = 32;
	localparam int ddrOpWidth = 5;
	localparam int ddrStatusWidth = 2;

	typedef enum logic [ddrOpWidth-1:0] {
		DDR_OP_READY = 5'h00,
		DDR_OP_RD_TILE = 5'h11,
		DDR_OP_WR_TILE = 5'h12
	} ddrOp;

	typedef enum logic [ddrStatusWidth-1:0] {
		DDR_ST_READY = 2'b00,
		DDR_ST_OK = 2'b01,
		DDR_ST_HOLD = 2'b10
	} ddrStatus;

	// RAM window, top two bits clear and not the low 16MB
	function automatic logic isCacheable(input logic [ringBusPkg::ringAddrWidth-1:0] addr);
		return (addr[31:30] == 2'b00) && (addr[29:24] != 6'h00);
	endfunction

	// hashed index spreads strided lines over the array
	function automatic logic [indexBits-1:0] lineIndex(input logic [lineAddrWidth-1:0] lineAddr);
		return lineAddr[indexBits-1:0] ^ lineAddr[2*indexBits-1:indexBits];
	endfunction

endpackage

// ==== logic/ringRequestDecode.sv ====
`timescale 1ns/100ps

module ringRequestDecode (
	input logic clock,
	input logic reset,
	input logic [ringBusPkg::ringSeqWidth-1:0] ringSeqIn,
	input logic [ringBusPkg::ringOpmWidth-1:0] ringOpmIn,
	input logic [ringBusPkg::ringAddrWidth-1:0] ringAddrIn,
	input logic [ringBusPkg::tileWidth-1:0] ringDataIn,
	output logic [l2CachePkg::indexBits-1:0] readIndex,
	output logic [ringBusPkg::ringAddrWidth-1:0] reqAddr,
	output logic [ringBusPkg::ringSeqWidth-1:0] reqSeq,
	output logic [ringBusPkg::ringOpmWidth-1:0] reqOpm,
	output logic [ringBusPkg::tileWidth-1:0] reqData,
	output logic reqLoad,
	output logic reqStore,
	output logic reqCacheable
);
	logic [ringBusPkg::ringSeqWidth-1:0] stage1Seq;
	logic [ringBusPkg::ringOpmWidth-1:0] stage1Opm;
	logic [ringBusPkg::ringAddrWidth-1:0] stage1Addr;
	logic [ringBusPkg::tileWidth-1:0] stage1Data;

	// stage 1, raw message
	always_ff @(posedge clock)
	begin
		stage1Seq <= ringSeqIn;
		stage1Opm <= ringOpmIn;
		stage1Addr <= ringAddrIn;
		stage1Data <= ringDataIn;
	end

	// array read lines up with stage 2
	assign readIndex = l2CachePkg::lineIndex(
		stage1Addr[ringBusPkg::ringAddrWidth-1:l2CachePkg::lineOffsetBits]);

	always_ff @(posedge clock)
	begin
		reqAddr <= stage1Addr;
		reqSeq <= stage1Seq;
		reqOpm <= stage1Opm;
		reqData <= stage1Data;
	end

	// prefetch ops are not classified, so they fall through
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqLoad <= 1'b0;
			reqStore <= 1'b0;
			reqCacheable <= 1'b0;
		end
		else
		begin
			reqLoad <= stage1Opm[7:0] == ringBusPkg::LDX;
			reqStore <= stage1Opm[7:0] == ringBusPkg::STX;
			reqCacheable <= l2CachePkg::isCacheable(stage1Addr);
		end
	end

endmodule

// ==== logic/l2TileArray.sv ====
`timescale 1ns/100ps

module l2TileArray (
	input logic clock,
	input logic reset,
	input logic [l2CachePkg::indexBits-1:0] readIndex,
	input logic writeEnable,
	input logic [l2CachePkg::indexBits-1:0] writeIndex,
	input logic [l2CachePkg::lineWidth-1:0] writeLine,
	input logic [l2CachePkg::tagWidth-1:0] writeTag,
	input logic writeDirty,
	output logic [l2CachePkg::lineWidth-1:0] readLine,
	output logic [l2CachePkg::tagWidth-1:0] readTag,
	output logic readDirty,
	output logic readValid
);
	logic [l2CachePkg::lineWidth-1:0] lineMem [l2CachePkg::lineCount];
	logic [l2CachePkg::tagWidth-1:0] tagMem [l2CachePkg::lineCount];
	logic [l2CachePkg::lineCount-1:0] dirtyBits;
	logic [l2CachePkg::lineCount-1:0] validBits;

	always_ff @(posedge clock)
	begin
		if (writeEnable)
		begin
			lineMem[writeIndex] <= writeLine;
			tagMem[writeIndex] <= writeTag;
			dirtyBits[writeIndex] <= writeDirty;
		end
	end

	// every line starts invalid
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			validBits <= '0;
		end
		else if (writeEnable)
		begin
			validBits[writeIndex] <= 1'b1;
		end
	end

	// read before write, same-edge writes are not seen
	always_ff @(posedge clock)
	begin
		readLine <= lineMem[readIndex];
		readTag <= tagMem[readIndex];
		readDirty <= dirtyBits[readIndex];
		readValid <= validBits[readIndex];
	end

endmodule

// ==== logic/l2HitControl.sv ====
`timescale 1ns/100ps

module l2HitControl (
	input logic clock,
	input logic reset,
	input logic [ringBusPkg::ringAddrWidth-1:0] reqAddr,
	input logic [ringBusPkg::ringSeqWidth-1:0] reqSeq,
	input logic [ringBusPkg::ringOpmWidth-1:0] reqOpm,
	input logic [ringBusPkg::tileWidth-1:0] reqData,
	input logic reqLoad,
	input logic reqStore,
	input logic reqCacheable,
	input logic [l2CachePkg::lineWidth-1:0] readLine,
	input logic [l2CachePkg::tagWidth-1:0] readTag,
	input logic readDirty,
	input logic readValid,
	input logic missBusy,
	input logic fillValid,
	input logic [l2CachePkg::indexBits-1:0] fillIndex,
	input logic [l2CachePkg::tagWidth-1:0] fillTag,
	input logic [l2CachePkg::lineWidth-1:0] fillLine,
	output logic writeEnable,
	output logic [l2CachePkg::indexBits-1:0] writeIndex,
	output logic [l2CachePkg::lineWidth-1:0] writeLine,
	output logic [l2CachePkg::tagWidth-1:0] writeTag,
	output logic writeDirty,
	output logic missStart,
	output logic [l2CachePkg::indexBits-1:0] missIndex,
	output logic [l2CachePkg::lineAddrWidth-1:0] missLineAddr,
	output logic [l2CachePkg::lineWidth-1:0] victimLine,
	output logic [l2CachePkg::tagWidth-1:0] victimTag,
	output logic victimDirty,
	output logic respond,
	output logic [ringBusPkg::tileWidth-1:0] responseData,
	output logic [ringBusPkg::ringSeqWidth-1:0] stageSeq,
	output logic [ringBusPkg::ringOpmWidth-1:0] stageOpm,
	output logic [ringBusPkg::ringAddrWidth-1:0] stageAddr,
	output logic [ringBusPkg::tileWidth-1:0] stageData
);
	logic [l2CachePkg::lineAddrWidth-1:0] reqLineAddr;
	logic [l2CachePkg::indexBits-1:0] reqIndex;
	logic [l2CachePkg::tileSelBits-1:0] tileSel;
	logic access;
	logic hit;
	logic hazard;
	logic pendingLine;
	logic loadHit;
	logic storeWrite;
	logic [l2CachePkg::lineWidth-1:0] mergedLine;
	logic lastWriteEnable;
	logic [l2CachePkg::indexBits-1:0] lastWriteIndex;

	assign reqLineAddr = reqAddr[ringBusPkg::ringAddrWidth-1:l2CachePkg::lineOffsetBits];
	assign reqIndex = l2CachePkg::lineIndex(reqLineAddr);
	assign tileSel = reqAddr[l2CachePkg::lineOffsetBits-1 -: l2CachePkg::tileSelBits];

	assign access = reqCacheable && (reqLoad || reqStore);
	assign hit = readValid && (readTag == reqLineAddr);
	// array read was stale if this index was written on the last edge
	assign hazard = lastWriteEnable && (lastWriteIndex == reqIndex);
	// the line under refill must not change before the fill lands
	assign pendingLine = missBusy && (fillIndex == reqIndex);

	assign loadHit = access && reqLoad && hit && !hazard && !pendingLine;
	// fill owns the write port in its cycle
	assign storeWrite = access && reqStore && hit && !hazard && !pendingLine && !fillValid;

	always_comb
	begin
		mergedLine = readLine;
		mergedLine[tileSel*ringBusPkg::tileWidth +: ringBusPkg::tileWidth] = reqData;
	end

	// array write port, fills are written clean
	assign writeEnable = fillValid || storeWrite;
	assign writeIndex = fillValid ? fillIndex : reqIndex;
	assign writeLine = fillValid ? fillLine : mergedLine;
	assign writeTag = fillValid ? fillTag : reqLineAddr;
	assign writeDirty = !fillValid;

	// miss hand-off, the requester retries meanwhile
	assign missStart = access && !hit && !hazard && !missBusy;
	assign missIndex = reqIndex;
	assign missLineAddr = reqLineAddr;
	assign victimLine = readLine;
	assign victimTag = readTag;
	assign victimDirty = readDirty && readValid;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			respond <= 1'b0;
			lastWriteEnable <= 1'b0;
		end
		else
		begin
			respond <= loadHit || storeWrite;
			lastWriteEnable <= writeEnable;
		end
	end

	always_ff @(posedge clock)
	begin
		lastWriteIndex <= writeIndex;
		responseData <= readLine[tileSel*ringBusPkg::tileWidth +: ringBusPkg::tileWidth];
		stageSeq <= reqSeq;
		stageOpm <= reqOpm;
		stageAddr <= reqAddr;
		stageData <= reqData;
	end

endmodule

// ==== logic/ddrMissEngine.sv ====
`timescale 1ns/100ps

module ddrMissEngine (
	input logic clock,
	input logic reset,
	input logic missStart,
	input logic [l2CachePkg::indexBits-1:0] missIndex,
	input logic [l2CachePkg::lineAddrWidth-1:0] missLineAddr,
	input logic [l2CachePkg::lineWidth-1:0] victimLine,
	input logic [l2CachePkg::tagWidth-1:0] victimTag,
	input logic victimDirty,
	input logic [l2CachePkg::lineWidth-1:0] ddrDataIn,
	input logic [l2CachePkg::ddrStatusWidth-1:0] ddrStatus,
	output logic missBusy,
	output logic fillValid,
	output logic [l2CachePkg::indexBits-1:0] fillIndex,
	output logic [l2CachePkg::tagWidth-1:0] fillTag,
	output logic [l2CachePkg::lineWidth-1:0] fillLine,
	output logic [l2CachePkg::ddrAddrWidth-1:0] ddrAddr,
	output logic [l2CachePkg::ddrOpWidth-1:0] ddrOpm,
	output logic [l2CachePkg::lineWidth-1:0] ddrDataOut
);
	typedef enum logic [2:0] {
		stateIdle,
		stateWriteBack,
		stateWriteBackRelease,
		stateRead,
		stateReadRelease,
		stateFill
	} missState;

	missState state;
	l2CachePkg::ddrOp opReg;
	logic [l2CachePkg::ddrAddrWidth-1:0] addrReg;
	logic [l2CachePkg::lineWidth-1:0] dataReg;
	logic [l2CachePkg::ddrStatusWidth-1:0] statusReg;
	logic [l2CachePkg::lineWidth-1:0] dataInReg;

	assign missBusy = state != stateIdle;
	assign fillValid = state == stateFill;

	// one register stage each way on the DDR side
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ddrOpm <= l2CachePkg::DDR_OP_READY;
			statusReg <= l2CachePkg::DDR_ST_READY;
		end
		else
		begin
			ddrOpm <= opReg;
			statusReg <= ddrStatus;
		end
	end

	always_ff @(posedge clock)
	begin
		ddrAddr <= addrReg;
		ddrDataOut <= dataReg;
		dataInReg <= ddrDataIn;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= stateIdle;
			opReg <= l2CachePkg::DDR_OP_READY;
		end
		else
		begin
			case (state)
				stateIdle:
				begin
					if (missStart)
					begin
						// dirty victim goes out before the new line comes in
						if (victimDirty)
						begin
							opReg <= l2CachePkg::DDR_OP_WR_TILE;
							state <= stateWriteBack;
						end
						else
						begin
							opReg <= l2CachePkg::DDR_OP_RD_TILE;
							state <= stateRead;
						end
					end
				end
				stateWriteBack:
				begin
					if (statusReg == l2CachePkg::DDR_ST_OK)
					begin
						opReg <= l2CachePkg::DDR_OP_READY;
						state <= stateWriteBackRelease;
					end
				end
				stateWriteBackRelease:
				begin
					if (statusReg == l2CachePkg::DDR_ST_READY)
					begin
						opReg <= l2CachePkg::DDR_OP_RD_TILE;
						state <= stateRead;
					end
				end
				stateRead:
				begin
					if (statusReg == l2CachePkg::DDR_ST_OK)
					begin
						opReg <= l2CachePkg::DDR_OP_READY;
						state <= stateReadRelease;
					end
				end
				stateReadRelease:
				begin
					if (statusReg == l2CachePkg::DDR_ST_READY)
						state <= stateFill;
				end
				default:
				begin
					state <= stateIdle;
				end
			endcase
		end
	end

	// address, write data and fill payload
	always_ff @(posedge clock)
	begin
		if (state == stateIdle && missStart)
		begin
			fillIndex <= missIndex;
			fillTag <= missLineAddr;
			dataReg <= victimLine;
			if (victimDirty)
				addrReg <= {victimTag, {l2CachePkg::lineOffsetBits{1'b0}}};
			else
				addrReg <= {missLineAddr, {l2CachePkg::lineOffsetBits{1'b0}}};
		end
		else if (state == stateWriteBackRelease && statusReg == l2CachePkg::DDR_ST_READY)
		begin
			addrReg <= {fillTag, {l2CachePkg::lineOffsetBits{1'b0}}};
		end
		if (state == stateRead && statusReg == l2CachePkg::DDR_ST_OK)
			fillLine <= dataInReg;
	end

endmodule

// ==== logic/ringResponseStage.sv ====
`timescale 1ns/100ps

module ringResponseStage (
	input logic clock,
	input logic reset,
	input logic respond,
	input logic [ringBusPkg::tileWidth-1:0] responseData,
	input logic [ringBusPkg::ringSeqWidth-1:0] stageSeq,
	input logic [ringBusPkg::ringOpmWidth-1:0] stageOpm,
	input logic [ringBusPkg::ringAddrWidth-1:0] stageAddr,
	input logic [ringBusPkg::tileWidth-1:0] stageData,
	output logic [ringBusPkg::ringSeqWidth-1:0] ringSeqOut,
	output logic [ringBusPkg::ringOpmWidth-1:0] ringOpmOut,
	output logic [ringBusPkg::ringAddrWidth-1:0] ringAddrOut,
	output logic [ringBusPkg::tileWidth-1:0] ringDataOut
);
	logic stageIsStore;
	logic [ringBusPkg::ringOpcodeWidth-1:0] okCode;

	assign stageIsStore = stageOpm[7:0] == ringBusPkg::STX;
	assign okCode = stageIsStore ? ringBusPkg::OKST : ringBusPkg::OKLD;

	always_ff @(posedge clock)
	begin
		if (reset)
			ringOpmOut <= {{(ringBusPkg::ringOpmWidth - 8){1'b0}}, ringBusPkg::IDLE};
		else if (respond)
			ringOpmOut <= {stageOpm[ringBusPkg::ringOpmWidth-1:8], okCode};
		else
			ringOpmOut <= stageOpm;
	end

	// seq and address always pass, data only swaps on a load response
	always_ff @(posedge clock)
	begin
		ringSeqOut <= stageSeq;
		ringAddrOut <= stageAddr;
		if (respond && !stageIsStore)
			ringDataOut <= responseData;
		else
			ringDataOut <= stageData;
	end

endmodule

// ==== logic/l2RingCache.sv ====
`timescale 1ns/100ps

module l2RingCache (
	input logic clock,
	input logic reset,
	input logic [ringBusPkg::ringSeqWidth-1:0] ringSeqIn,
	input logic [ringBusPkg::ringOpmWidth-1:0] ringOpmIn,
	input logic [ringBusPkg::ringAddrWidth-1:0] ringAddrIn,
	input logic [ringBusPkg::tileWidth-1:0] ringDataIn,
	output logic [ringBusPkg::ringSeqWidth-1:0] ringSeqOut,
	output logic [ringBusPkg::ringOpmWidth-1:0] ringOpmOut,
	output logic [ringBusPkg::ringAddrWidth-1:0] ringAddrOut,
	output logic [ringBusPkg::tileWidth-1:0] ringDataOut,
	output logic [l2CachePkg::ddrAddrWidth-1:0] ddrAddr,
	output logic [l2CachePkg::ddrOpWidth-1:0] ddrOpm,
	output logic [l2CachePkg::lineWidth-1:0] ddrDataOut,
	input logic [l2CachePkg::lineWidth-1:0] ddrDataIn,
	input logic [l2CachePkg::ddrStatusWidth-1:0] ddrStatus
);
	// stage 2 request
	logic [l2CachePkg::indexBits-1:0] readIndex;
	logic [ringBusPkg::ringAddrWidth-1:0] reqAddr;
	logic [ringBusPkg::ringSeqWidth-1:0] reqSeq;
	logic [ringBusPkg::ringOpmWidth-1:0] reqOpm;
	logic [ringBusPkg::tileWidth-1:0] reqData;
	logic reqLoad;
	logic reqStore;
	logic reqCacheable;
	// array ports
	logic [l2CachePkg::lineWidth-1:0] readLine;
	logic [l2CachePkg::tagWidth-1:0] readTag;
	logic readDirty;
	logic readValid;
	logic writeEnable;
	logic [l2CachePkg::indexBits-1:0] writeIndex;
	logic [l2CachePkg::lineWidth-1:0] writeLine;
	logic [l2CachePkg::tagWidth-1:0] writeTag;
	logic writeDirty;
	// miss hand-off and fill return
	logic missStart;
	logic [l2CachePkg::indexBits-1:0] missIndex;
	logic [l2CachePkg::lineAddrWidth-1:0] missLineAddr;
	logic [l2CachePkg::lineWidth-1:0] victimLine;
	logic [l2CachePkg::tagWidth-1:0] victimTag;
	logic victimDirty;
	logic missBusy;
	logic fillValid;
	logic [l2CachePkg::indexBits-1:0] fillIndex;
	logic [l2CachePkg::tagWidth-1:0] fillTag;
	logic [l2CachePkg::lineWidth-1:0] fillLine;
	// stage 3
	logic respond;
	logic [ringBusPkg::tileWidth-1:0] responseData;
	logic [ringBusPkg::ringSeqWidth-1:0] stageSeq;
	logic [ringBusPkg::ringOpmWidth-1:0] stageOpm;
	logic [ringBusPkg::ringAddrWidth-1:0] stageAddr;
	logic [ringBusPkg::tileWidth-1:0] stageData;

	ringRequestDecode decode (.*);

	l2TileArray tileArray (.*);

	l2HitControl hitControl (.*);

	ddrMissEngine missEngine (.*);

	ringResponseStage responseStage (.*);

endmodule

// ==== verification/ddrMissEngine_asserts.sv ====
`timescale 1ns/100ps

module ddrMissEngineAsserts (
	input logic clock,
	input logic reset,
	input logic [l2CachePkg::ddrOpWidth-1:0] ddrOpm,
	input logic [l2CachePkg::ddrAddrWidth-1:0] ddrAddr,
	input logic [l2CachePkg::ddrStatusWidth-1:0] ddrStatus,
	input logic fillValid
);
	int failureCount = 0;

	// op register comes out of reset idle
	opReadyAfterReset: assert property (@(posedge clock)
		reset |=> ddrOpm == l2CachePkg::DDR_OP_READY)
		else
		begin
			$error("DDR op is not READY after reset");
			failureCount++;
		end

	// an issued op holds until the memory answers OK
	opHeldUntilOk: assert property (@(posedge clock) disable iff (reset)
		(ddrOpm != l2CachePkg::DDR_OP_READY && ddrStatus != l2CachePkg::DDR_ST_OK)
		|=> ($stable(ddrOpm) && $stable(ddrAddr)))
		else
		begin
			$error("DDR op or address changed before OK");
			failureCount++;
		end

	fillIsOnePulse: assert property (@(posedge clock) disable iff (reset)
		fillValid |=> !fillValid)
		else
		begin
			$error("fill strobe longer than one cycle");
			failureCount++;
		end

endmodule

bind ddrMissEngine ddrMissEngineAsserts protocolChecks (
	.clock(clock),
	.reset(reset),
	.ddrOpm(ddrOpm),
	.ddrAddr(ddrAddr),
	.ddrStatus(ddrStatus),
	.fillValid(fillValid)
);

// ==== verification/l2RingCacheTb.sv ====
`timescale 1ns/100ps

module l2RingCacheTb;
	localparam int retryLimit = 50;
	localparam int waitLimit = 2000;

	logic clock;
	logic reset;
	logic [ringBusPkg::ringSeqWidth-1:0] ringSeqIn;
	logic [ringBusPkg::ringOpmWidth-1:0] ringOpmIn;
	logic [ringBusPkg::ringAddrWidth-1:0] ringAddrIn;
	logic [ringBusPkg::tileWidth-1:0] ringDataIn;
	logic [ringBusPkg::ringSeqWidth-1:0] ringSeqOut;
	logic [ringBusPkg::ringOpmWidth-1:0] ringOpmOut;
	logic [ringBusPkg::ringAddrWidth-1:0] ringAddrOut;
	logic [ringBusPkg::tileWidth-1:0] ringDataOut;
	logic [l2CachePkg::ddrAddrWidth-1:0] ddrAddr;
	logic [l2CachePkg::ddrOpWidth-1:0] ddrOpm;
	logic [l2CachePkg::lineWidth-1:0] ddrDataOut;
	logic [l2CachePkg::lineWidth-1:0] ddrDataIn;
	logic [l2CachePkg::ddrStatusWidth-1:0] ddrStatus;

	int cycle = 0;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int resultCount = 0;
	int maxHold = 3;
	bit lastResponded = 0;
	bit runDone = 0;

	// messages in flight until their output is due
	int dueQ[$];
	logic [15:0] seqQ[$];
	logic [15:0] opmQ[$];
	logic [31:0] addrQ[$];
	logic [127:0] dataQ[$];

	// stored tiles keyed by tile address and DDR lines by line address
	logic [127:0] shadowTiles [logic [31:0]];
	logic [511:0] ddrLines [logic [25:0]];
	logic [25:0] writeAddrLog[$];
	logic [511:0] writeDataLog[$];

	l2RingCache UUT (.*);

	always #4 clock = ~clock;

	always @(posedge clock)
		cycle++;

	function automatic logic [127:0] patternTile(input logic [31:0] tileAddr);
		return {tileAddr ^ 32'h5a5a_0f0f, ~tileAddr, tileAddr * 32'h9e37_79b9,
			{tileAddr[15:0], tileAddr[31:16]}};
	endfunction

	function automatic logic [511:0] patternLine(input logic [25:0] lineAddr);
		logic [511:0] line;
		for (int i = 0; i < 4; i++)
			line[i*128 +: 128] = patternTile({lineAddr, i[1:0]});
		return line;
	endfunction

	// last stored tile wins over the memory pattern
	function automatic logic [127:0] expectedTile(input logic [31:0] addr);
		logic [31:0] tileAddr;
		tileAddr = addr >> 4;
		if (shadowTiles.exists(tileAddr))
			return shadowTiles[tileAddr];
		return patternTile(tileAddr);
	endfunction

	function automatic logic [511:0] expectedLine(input logic [25:0] lineAddr);
		logic [511:0] line;
		for (int i = 0; i < 4; i++)
			line[i*128 +: 128] = expectedTile({lineAddr, i[1:0], 4'h0});
		return line;
	endfunction

	function automatic bit inRamWindow(input logic [31:0] addr);
		return addr[31:30] == 2'b00 && addr[29:24] != 6'h00;
	endfunction

	task automatic reportMismatch(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errorCount++;
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testsRun++;
		if (errorCount == errorsBefore)
			$display("test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	task automatic driveMessage(input logic [15:0] seq, input logic [15:0] opm,
		input logic [31:0] addr, input logic [127:0] data);
		@(posedge clock);
		#1;
		ringSeqIn = seq;
		ringOpmIn = opm;
		ringAddrIn = addr;
		ringDataIn = data;
		// sampled on the next edge and out three edges after that
		dueQ.push_back(cycle + 4);
		seqQ.push_back(seq);
		opmQ.push_back(opm);
		addrQ.push_back(addr);
		dataQ.push_back(data);
	endtask

	task automatic driveIdle();
		@(posedge clock);
		#1;
		ringOpmIn = '0;
	endtask

	task automatic waitResults(input int target);
		int waited;
		waited = 0;
		while (resultCount < target && waited < waitLimit)
		begin
			@(posedge clock);
			waited++;
		end
		if (resultCount < target)
		begin
			$display("timeout at %0t: ring output never arrived", $time);
			errorCount++;
		end
	endtask

	task automatic requestUntilServed(input logic [15:0] opm, input logic [31:0] addr,
		input logic [127:0] data, output int attempts);
		bit served;
		int target;
		attempts = 0;
		served = 0;
		while (!served && attempts < retryLimit)
		begin
			target = resultCount + 1;
			driveMessage($urandom_range(16'hffff, 0), opm, addr, data);
			driveIdle();
			waitResults(target);
			attempts++;
			served = lastResponded;
			if (!served)
				repeat (6) @(posedge clock);
		end
		if (!served)
		begin
			$display("request %h to %h was not served after %0d tries", opm, addr, retryLimit);
			errorCount++;
		end
	endtask

	// each output is either a pass-through or a response matching the reference
	always @(negedge clock)
	begin : compareOutput
		logic [15:0] seq;
		logic [15:0] opm;
		logic [31:0] addr;
		logic [127:0] data;
		bit served;
		if (dueQ.size() > 0 && dueQ[0] == cycle)
		begin
			void'(dueQ.pop_front());
			seq = seqQ.pop_front();
			opm = opmQ.pop_front();
			addr = addrQ.pop_front();
			data = dataQ.pop_front();
			served = 0;
			if (ringSeqOut != seq || ringAddrOut != addr)
				reportMismatch($sformatf("seq/addr %h/%h came back as %h/%h",
					seq, addr, ringSeqOut, ringAddrOut));
			if (ringOpmOut == opm && ringDataOut == data)
				served = 0;
			else if (opm[7:0] == ringBusPkg::LDX && inRamWindow(addr)
				&& ringOpmOut == {opm[15:8], ringBusPkg::OKLD})
			begin
				served = 1;
				if (ringDataOut != expectedTile(addr))
					reportMismatch($sformatf("load %h returned %h, expected %h",
						addr, ringDataOut, expectedTile(addr)));
			end
			else if (opm[7:0] == ringBusPkg::STX && inRamWindow(addr)
				&& ringOpmOut == {opm[15:8], ringBusPkg::OKST})
			begin
				served = 1;
				if (ringDataOut != data)
					reportMismatch($sformatf("store %h response data %h", addr, ringDataOut));
				shadowTiles[addr >> 4] = data;
			end
			else
				reportMismatch($sformatf("opm %h to %h came back as %h", opm, addr, ringOpmOut));
			lastResponded = served;
			resultCount++;
		end
	end

	// DDR model answers with HOLD then a short delay before OK
	initial
	begin : ddrModel
		logic [25:0] lineAddr;
		int holdCycles;
		int delayCycles;
		int waited;
		ddrStatus = l2CachePkg::DDR_ST_READY;
		ddrDataIn = '0;
		while (!runDone)
		begin
			@(posedge clock);
			#1;
			if (!reset && ddrOpm != l2CachePkg::DDR_OP_READY)
			begin
				lineAddr = ddrAddr[31:6];
				holdCycles = $urandom_range(maxHold, 0);
				delayCycles = $urandom_range(6, 1);
				for (int i = 0; i < holdCycles + delayCycles; i++)
				begin
					if (i < holdCycles)
						ddrStatus = l2CachePkg::DDR_ST_HOLD;
					else
						ddrStatus = l2CachePkg::DDR_ST_READY;
					@(posedge clock);
					#1;
				end
				if (ddrOpm == l2CachePkg::DDR_OP_WR_TILE)
				begin
					writeAddrLog.push_back(lineAddr);
					writeDataLog.push_back(ddrDataOut);
					if (ddrDataOut != expectedLine(lineAddr))
						reportMismatch($sformatf("write-back of line %h has wrong data", lineAddr));
					ddrLines[lineAddr] = ddrDataOut;
				end
				else if (ddrLines.exists(lineAddr))
					ddrDataIn = ddrLines[lineAddr];
				else
					ddrDataIn = patternLine(lineAddr);
				ddrStatus = l2CachePkg::DDR_ST_OK;
				waited = 0;
				while (ddrOpm != l2CachePkg::DDR_OP_READY && waited < waitLimit)
				begin
					@(posedge clock);
					#1;
					waited++;
				end
				if (ddrOpm != l2CachePkg::DDR_OP_READY)
				begin
					$display("DDR op at %0t was never released after OK", $time);
					errorCount++;
				end
				ddrStatus = l2CachePkg::DDR_ST_READY;
			end
		end
	end

	initial
	begin : mainSequence
		int attempts;
		int firstErrors;
		int writesBefore;
		int target;
		int protocolFailures;
		logic [31:0] addrA;
		logic [31:0] addrB;
		logic [31:0] addr;
		logic [25:0] line;
		logic [127:0] storeData;
		logic [7:0] hiByte;
		int k;
		void'($urandom(32'he0c9_bd41));
		clock = 0;
		reset = 1;
		ringSeqIn = '0;
		ringOpmIn = '0;
		ringAddrIn = '0;
		ringDataIn = '0;
		repeat (4) @(posedge clock);
		#1;
		reset = 0;

		// reset values and then traffic the cache ignores
		firstErrors = errorCount;
		if (ringOpmOut != 16'h0000 || ddrOpm != l2CachePkg::DDR_OP_READY)
			reportMismatch($sformatf("after reset opm %h ddr op %h", ringOpmOut, ddrOpm));
		target = resultCount + 4;
		driveMessage(16'h0011, {8'h00, ringBusPkg::IDLE}, 32'h0100_0000, 128'h1);
		driveMessage(16'h0012, {8'h21, ringBusPkg::LDX}, 32'h0012_3450, 128'h2);
		driveMessage(16'h0013, {8'h22, ringBusPkg::STX}, 32'hc100_0010, 128'h3);
		driveMessage(16'h0014, {8'h23, ringBusPkg::PFX}, 32'h0100_0080, 128'h4);
		driveIdle();
		waitResults(target);
		reportTest("pass-through", firstErrors);

		firstErrors = errorCount;
		addrA = 32'h0100_0040;
		hiByte = $urandom_range(255, 0);
		requestUntilServed({hiByte, ringBusPkg::LDX}, addrA, '0, attempts);
		if (attempts < 2)
		begin
			$display("first load to %h was served without missing", addrA);
			errorCount++;
		end
		reportTest("load miss then hit", firstErrors);

		firstErrors = errorCount;
		storeData = {$urandom, $urandom, $urandom, $urandom};
		requestUntilServed({hiByte, ringBusPkg::STX}, addrA + 32'h20, storeData, attempts);
		for (int i = 0; i < 4; i++)
			requestUntilServed({hiByte, ringBusPkg::LDX}, addrA + i * 16, '0, attempts);
		reportTest("store then load line", firstErrors);

		// addrB shares the hashed index so the dirty line goes back to DDR
		firstErrors = errorCount;
		addrB = 32'h0100_4000;
		writesBefore = writeAddrLog.size();
		requestUntilServed({hiByte, ringBusPkg::LDX}, addrB, '0, attempts);
		if (writeAddrLog.size() != writesBefore + 1)
			reportMismatch($sformatf("%0d write-backs, expected 1",
				writeAddrLog.size() - writesBefore));
		else if (writeAddrLog[writesBefore] != addrA[31:6]
			|| writeDataLog[writesBefore] != expectedLine(addrA[31:6]))
			reportMismatch($sformatf("write-back went to line %h", writeAddrLog[writesBefore]));
		requestUntilServed({hiByte, ringBusPkg::LDX}, addrA + 32'h20, '0, attempts);
		reportTest("dirty eviction", firstErrors);

		// two indices with three lines each under slow DDR
		firstErrors = errorCount;
		maxHold = 30;
		for (int n = 0; n < 40; n++)
		begin
			k = $urandom_range(5, 0);
			line = (k < 3) ? 26'h40001 : 26'h40005;
			line = line ^ ((k % 3) * 26'h101);
			addr = {line, 6'h00} + $urandom_range(3, 0) * 16;
			hiByte = $urandom_range(255, 0);
			if ($urandom_range(1, 0) == 1)
			begin
				storeData = {$urandom, $urandom, $urandom, $urandom};
				requestUntilServed({hiByte, ringBusPkg::STX}, addr, storeData, attempts);
			end
			else
				requestUntilServed({hiByte, ringBusPkg::LDX}, addr, '0, attempts);
		end
		reportTest("random traffic with HOLD", firstErrors);

		runDone = 1;
		protocolFailures = UUT.missEngine.protocolChecks.failureCount;
		if (protocolFailures != 0)
			$display("%0d DDR protocol assertions failed during the run", protocolFailures);
		errorCount += protocolFailures;
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
logic/ringBusPkg.sv
logic/l2CachePkg.sv
logic/ringRequestDecode.sv
logic/l2TileArray.sv
logic/l2HitControl.sv
logic/ddrMissEngine.sv
logic/ringResponseStage.sv
logic/l2RingCache.sv
verification/ddrMissEngine_asserts.sv
verification/l2RingCacheTb.sv
